/* Makefile */
# Verilator build and run of the floating-point add accelerator testbench

VERILATOR ?= verilator
TOP       ?= fp_accel_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), verdict from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, no verdict"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/fp_accel_tb.sv */
/*
 * testbench of the floating-point add accelerator
 * directed AXI4-Lite tests of sums, rounding, special values and registers
 */
module fp_accel_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PERIOD_NS  = 4;
    localparam int          SETTLE_NS  = 1;     // sample point after the falling edge
    localparam int          HS_TIMEOUT = 16;    // cycles per handshake
    localparam int          POLL_LIMIT = 12;    // STATUS reads before giving up
    localparam logic [31:0] SEED       = 32'd83861;
    localparam logic [31:0] ONE        = 32'h3F80_0000;
    localparam logic [31:0] QNAN_WORD  = 32'h7FC0_0000;
    localparam logic [31:0] POS_INF    = 32'h7F80_0000;

    logic                      CLK;
    logic                      Reset;
    logic [fp_pkg::ADDR_W-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [31:0]               wdata;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [fp_pkg::ADDR_W-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    int          n_checks;
    int          n_errors;
    logic [31:0] rng_state;

    fp_accel_top dut (
        .CLK     (CLK),
        .Reset   (Reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(PERIOD_NS / 2) CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // random sign and magnitude below 2^20
    function automatic int next_operand();
        rng_state = xorshift(rng_state);
        return rng_state[31] ? -int'(rng_state[19:0]) : int'(rng_state[19:0]);
    endfunction

    // exact binary32 word of an integer below 2^24 in magnitude
    function automatic logic [31:0] make_float(input int value);
        logic [31:0] mag;
        logic [31:0] frac;
        int          msb;
        int          i;
        if (value == 0)
            return 32'd0;
        mag = (value < 0) ? 32'(-value) : 32'(value);
        msb = 0;
        for (i = 0; i < 24; i++)
            if (mag[i])
                msb = i;
        frac = mag << (23 - msb);   // leading one on bit 23
        return {value < 0, 8'(127 + msb), frac[22:0]};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s got %08h, expected %08h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // called and returning on a falling edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        n = 0;
        #SETTLE_NS;
        while (!(awready && wready) && n < HS_TIMEOUT) begin
            @(negedge CLK);
            #SETTLE_NS;
            n++;
        end
        if (!(awready && wready))
            report_timeout("write address and data were never accepted");
        @(negedge CLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        #SETTLE_NS;
        while (!bvalid && n < HS_TIMEOUT) begin
            @(negedge CLK);
            #SETTLE_NS;
            n++;
        end
        if (!bvalid)
            report_timeout("no write response arrived");
        resp = bresp;
        @(negedge CLK);
    endtask

    // stall > 0 keeps rready low that many cycles after rvalid
    task automatic axi_read(input logic [4:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (stall == 0);
        n = 0;
        #SETTLE_NS;
        while (!arready && n < HS_TIMEOUT) begin
            @(negedge CLK);
            #SETTLE_NS;
            n++;
        end
        if (!arready)
            report_timeout("read address was never accepted");
        @(negedge CLK);
        arvalid = 1'b0;
        n = 0;
        #SETTLE_NS;
        while (!rvalid && n < HS_TIMEOUT) begin
            @(negedge CLK);
            #SETTLE_NS;
            n++;
        end
        if (!rvalid)
            report_timeout("no read data arrived");
        data = rdata;
        resp = rresp;
        if (stall > 0) begin
            repeat (stall) begin
                @(negedge CLK);
                #SETTLE_NS;
                check_word("rvalid during stall", {31'd0, rvalid}, 32'd1);
                check_word("rdata during stall", rdata, data);
            end
            @(negedge CLK);
            rready = 1'b1;
        end
        @(negedge CLK);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT) begin
            axi_read(fp_pkg::REG_STATUS, 0, status, resp);
            polls++;
        end
        if (!status[1])
            report_timeout("STATUS never showed done");
    endtask

    task automatic check_op(input string name, input logic [31:0] a, input logic [31:0] b,
                            input logic sub, input logic [31:0] exp);
        logic [1:0]  resp;
        logic [31:0] result;
        axi_write(fp_pkg::REG_OPA, a, resp);
        axi_write(fp_pkg::REG_OPB, b, resp);
        axi_write(fp_pkg::REG_CTRL, {30'd0, sub, 1'b1}, resp);
        check_word({"bresp of start for ", name}, {30'd0, resp}, 32'd0);
        wait_done();
        axi_read(fp_pkg::REG_RESULT, 0, result, resp);
        check_word({"RESULT of ", name}, result, exp);
    endtask

    task automatic reset_values();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(fp_pkg::REG_STATUS, 0, data, resp);
        check_word("STATUS after reset", data, 32'd0);
        axi_read(fp_pkg::REG_RESULT, 0, data, resp);
        check_word("RESULT after reset", data, 32'd0);
    endtask

    task automatic exact_sums();
        int a;
        int b;
        check_op("1.5 + 2.25", 32'h3FC0_0000, 32'h4010_0000, 1'b0, 32'h4070_0000);
        check_op("5.0 - 7.0", 32'h40A0_0000, 32'h40E0_0000, 1'b1, 32'hC000_0000);
        repeat (200) begin
            a = next_operand();
            b = next_operand();
            check_op($sformatf("%0d + %0d", a, b), make_float(a), make_float(b), 1'b0,
                     make_float(a + b));
            check_op($sformatf("%0d - %0d", a, b), make_float(a), make_float(b), 1'b1,
                     make_float(a - b));
        end
    endtask

    task automatic nearest_even();
        check_op("1 + 2^-24", ONE, 32'h3380_0000, 1'b0, ONE);                 // tie to even
        check_op("1 + 3*2^-24", ONE, 32'h3440_0000, 1'b0, 32'h3F80_0002);
        check_op("3F800001 + 2^-24", 32'h3F80_0001, 32'h3380_0000, 1'b0, 32'h3F80_0002);
        check_op("max + max", 32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, POS_INF);
    endtask

    task automatic zeros_denormals();
        check_op("pi + 0", 32'h4049_0FDB, 32'h0, 1'b0, 32'h4049_0FDB);
        check_op("-3.0 + 0", 32'hC040_0000, 32'h0, 1'b0, 32'hC040_0000);
        check_op("pi - pi", 32'h4049_0FDB, 32'h4049_0FDB, 1'b1, 32'h0);
        check_op("-3.0 - -3.0", 32'hC040_0000, 32'hC040_0000, 1'b1, 32'h0);
        check_op("min denormal doubled", 32'h1, 32'h1, 1'b0, 32'h2);
        check_op("denormal to min normal", 32'h0040_0000, 32'h0040_0000, 1'b0, 32'h0080_0000);
    endtask

    task automatic special_values();
        check_op("NaN + 1.0", 32'h7F80_0001, ONE, 1'b0, QNAN_WORD);
        check_op("1.0 - NaN", ONE, 32'hFFC1_2345, 1'b1, QNAN_WORD);
        check_op("inf - inf", POS_INF, POS_INF, 1'b1, QNAN_WORD);
        check_op("-inf + 5.0", 32'hFF80_0000, 32'h40A0_0000, 1'b0, 32'hFF80_0000);
        check_op("inf + inf", POS_INF, POS_INF, 1'b0, POS_INF);
    endtask

    task automatic register_protocol();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(fp_pkg::REG_OPA, 32'hDEAD_BEEF, resp);
        axi_read(fp_pkg::REG_OPA, 0, data, resp);
        check_word("OPA readback", data, 32'hDEAD_BEEF);
        axi_read(fp_pkg::REG_CTRL, 0, data, resp);
        check_word("CTRL readback", data, 32'd0);
        axi_write(5'h14, 32'h1234_5678, resp);
        check_word("bresp of write to 0x14", {30'd0, resp}, 32'd2);
        axi_read(5'h18, 0, data, resp);
        check_word("rresp of read from 0x18", {30'd0, resp}, 32'd2);

        // 3.0 + 4.0 with a second start right behind it
        axi_write(fp_pkg::REG_OPA, 32'h4040_0000, resp);
        axi_write(fp_pkg::REG_OPB, 32'h4080_0000, resp);
        axi_write(fp_pkg::REG_CTRL, 32'h1, resp);
        check_word("bresp of first start", {30'd0, resp}, 32'd0);
        axi_write(fp_pkg::REG_CTRL, 32'h3, resp);
        check_word("bresp of start while busy", {30'd0, resp}, 32'd2);
        wait_done();
        axi_read(fp_pkg::REG_RESULT, 0, data, resp);
        check_word("RESULT after refused start", data, 32'h40E0_0000);

        // 3.0 - 4.0 completes while rready is held low
        axi_write(fp_pkg::REG_CTRL, 32'h3, resp);
        check_word("bresp of second start", {30'd0, resp}, 32'd0);
        axi_read(fp_pkg::REG_RESULT, 5, data, resp);
        check_word("RESULT held through stall", data, 32'h40E0_0000);
        check_word("rresp of stalled read", {30'd0, resp}, 32'd0);
        wait_done();
        axi_read(fp_pkg::REG_RESULT, 0, data, resp);
        check_word("RESULT of 3.0 - 4.0", data, 32'hBF80_0000);
    endtask

    initial begin
        CLK       = 1'b0;
        Reset     = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        n_checks  = 0;
        n_errors  = 0;
        rng_state = SEED;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;

        reset_values();
        exact_sums();
        nearest_even();
        zeros_denormals();
        special_values();
        register_protocol();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* files.f */
verilog/fp_pkg.sv
verilog/fp_op_if.sv
verilog/lead_one_enc.sv
verilog/fp_add_core.sv
verilog/fp_axil_regs.sv
verilog/fp_accel_top.sv
dv/fp_accel_tb.sv

/* verilog/fp_accel_top.sv */
/*
 * floating-point add accelerator, AXI4-Lite slave
 * register block driving the binary32 add/subtract core
 */
module fp_accel_top (
    input  logic                      CLK,
    input  logic                      Reset,
    input  logic [fp_pkg::ADDR_W-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [fp_pkg::ADDR_W-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    fp_op_if op_if ();

    fp_axil_regs u_regs (
        .CLK     (CLK),
        .Reset   (Reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .port    (op_if.host)
    );

    fp_add_core u_core (
        .CLK   (CLK),
        .Reset (Reset),
        .port  (op_if.core)
    );

endmodule

/* verilog/fp_add_core.sv */
/*
 * binary32 add/subtract core
 * capture, align and add, then normalize and round to nearest even
 * one operation at a time, done three edges after start
 */
module fp_add_core (
    input logic   CLK,
    input logic   Reset,
    fp_op_if.core port
);

    fp_pkg::add_state_e state;

    // unpacked operands, B already carries the effective sign
    logic                       sign_a;
    logic                       sign_b;
    logic [fp_pkg::EXP_W-1:0]   exp_a;
    logic [fp_pkg::EXP_W-1:0]   exp_b;
    logic [fp_pkg::MAN_W:0]     man_a;
    logic [fp_pkg::MAN_W:0]     man_b;
    logic                       spec_q;
    logic [31:0]                spec_word;

    logic [fp_pkg::EXP_W-1:0]   in_exp_a;
    logic [fp_pkg::EXP_W-1:0]   in_exp_b;
    logic [fp_pkg::MAN_W-1:0]   in_frac_a;
    logic [fp_pkg::MAN_W-1:0]   in_frac_b;
    logic                       in_sign_b;
    logic                       nan_a;
    logic                       nan_b;
    logic                       inf_a;
    logic                       inf_b;
    logic                       spec_in;
    logic [31:0]                spec_in_word;

    logic                       a_big;
    logic [fp_pkg::EXP_W-1:0]   exp_diff;
    logic [4:0]                 shamt;
    logic [fp_pkg::FRAC_W-1:0]  big_ext;
    logic [fp_pkg::FRAC_W-1:0]  small_ext;
    logic [fp_pkg::FRAC_W-1:0]  small_sh;
    logic [fp_pkg::FRAC_W-1:0]  small_mask;
    logic [fp_pkg::FRAC_W-1:0]  aligned;
    logic [fp_pkg::FRAC_W-1:0]  sum_d;
    logic                       sign_d;

    logic [fp_pkg::FRAC_W-1:0]  sum_q;
    logic [fp_pkg::EXP_W-1:0]   sum_exp;
    logic                       sum_sign;

    logic [4:0]                 lead_pos;
    logic                       lead_found;
    logic [4:0]                 lead_dist;
    logic [fp_pkg::EXP_W-1:0]   shift_lim;
    logic [4:0]                 norm_sh;
    logic [fp_pkg::FRAC_W-1:0]  norm_frac;
    logic [9:0]                 norm_exp;
    logic                       round_up;
    logic [fp_pkg::MAN_W+1:0]   rnd;
    logic [fp_pkg::MAN_W:0]     fin_man;
    logic [9:0]                 fin_exp;
    logic [31:0]                packed_res;
    logic [31:0]                result_q;

    assign in_exp_a  = port.opa[30:23];
    assign in_exp_b  = port.opb[30:23];
    assign in_frac_a = port.opa[22:0];
    assign in_frac_b = port.opb[22:0];
    assign in_sign_b = port.opb[31] ^ (port.op == fp_pkg::FP_SUB);

    assign inf_a = (in_exp_a == fp_pkg::EXP_MAX) && (in_frac_a == '0);
    assign inf_b = (in_exp_b == fp_pkg::EXP_MAX) && (in_frac_b == '0);
    assign nan_a = (in_exp_a == fp_pkg::EXP_MAX) && (in_frac_a != '0);
    assign nan_b = (in_exp_b == fp_pkg::EXP_MAX) && (in_frac_b != '0);

    // NaN and infinity bypass the datapath
    always_comb begin
        spec_in      = 1'b1;
        spec_in_word = fp_pkg::QNAN;
        if (nan_a || nan_b || (inf_a && inf_b && (port.opa[31] != in_sign_b)))
            spec_in_word = fp_pkg::QNAN;
        else if (inf_a)
            spec_in_word = {port.opa[31], fp_pkg::EXP_MAX, {fp_pkg::MAN_W{1'b0}}};
        else if (inf_b)
            spec_in_word = {in_sign_b, fp_pkg::EXP_MAX, {fp_pkg::MAN_W{1'b0}}};
        else
            spec_in = 1'b0;
    end

    assign a_big     = {exp_a, man_a} >= {exp_b, man_b};
    assign exp_diff  = a_big ? exp_a - exp_b : exp_b - exp_a;
    assign big_ext   = {1'b0, a_big ? man_a : man_b, 3'b000};
    assign small_ext = {1'b0, a_big ? man_b : man_a, 3'b000};
    assign shamt     = (exp_diff >= (fp_pkg::EXP_W)'(fp_pkg::FRAC_W)) ?
                       5'(fp_pkg::FRAC_W) : exp_diff[4:0];

    assign small_sh   = small_ext >> shamt;
    assign small_mask = ~({fp_pkg::FRAC_W{1'b1}} << shamt);   // bits shifted out
    assign aligned    = {small_sh[fp_pkg::FRAC_W-1:1],
                         small_sh[0] | (|(small_ext & small_mask))};
    assign sum_d      = (sign_a ^ sign_b) ? big_ext - aligned : big_ext + aligned;
    assign sign_d     = (sum_d == '0) ? (sign_a & sign_b) : (a_big ? sign_a : sign_b);

    lead_one_enc u_lead (
        .in    ({{(32 - fp_pkg::FRAC_W){1'b0}}, sum_q}),
        .pos   (lead_pos),
        .found (lead_found)
    );

    // left shift stops at exponent one, rest stays denormal
    assign lead_dist = 5'(fp_pkg::FRAC_W - 2) - lead_pos;
    assign shift_lim = sum_exp - 1'b1;
    assign norm_sh   = ({3'b000, lead_dist} > shift_lim) ? shift_lim[4:0] : lead_dist;

    always_comb begin
        if (sum_q[fp_pkg::FRAC_W-1]) begin    // carry out
            norm_frac = {1'b0, sum_q[fp_pkg::FRAC_W-1:2], |sum_q[1:0]};
            norm_exp  = {2'b00, sum_exp} + 10'd1;
        end else begin
            norm_frac = sum_q << norm_sh;
            norm_exp  = {2'b00, sum_exp} - {5'd0, norm_sh};
        end
    end

    assign round_up = norm_frac[2] & (norm_frac[1] | norm_frac[0] | norm_frac[3]);
    assign rnd      = {1'b0, norm_frac[fp_pkg::FRAC_W-2:3]} + {{(fp_pkg::MAN_W+1){1'b0}}, round_up};

    always_comb begin
        if (rnd[fp_pkg::MAN_W+1]) begin
            fin_man = rnd[fp_pkg::MAN_W+1:1];
            fin_exp = norm_exp + 10'd1;
        end else begin
            fin_man = rnd[fp_pkg::MAN_W:0];
            fin_exp = norm_exp;
        end
    end

    // hidden bit clear means denormal, exponent field 0
    always_comb begin
        if (!lead_found)
            packed_res = {sum_sign, 31'd0};
        else if (fin_exp >= {2'b00, fp_pkg::EXP_MAX})
            packed_res = {sum_sign, fp_pkg::EXP_MAX, {fp_pkg::MAN_W{1'b0}}};
        else
            packed_res = {sum_sign,
                          fin_man[fp_pkg::MAN_W] ? fin_exp[fp_pkg::EXP_W-1:0] : {fp_pkg::EXP_W{1'b0}},
                          fin_man[fp_pkg::MAN_W-1:0]};
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= fp_pkg::ADD_IDLE;
        end else begin
            case (state)
                fp_pkg::ADD_IDLE:  if (port.start) state <= fp_pkg::ADD_ALIGN;
                fp_pkg::ADD_ALIGN: state <= fp_pkg::ADD_NORM;
                fp_pkg::ADD_NORM:  state <= fp_pkg::ADD_DONE;
                default:           state <= fp_pkg::ADD_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == fp_pkg::ADD_IDLE && port.start) begin
            sign_a    <= port.opa[31];
            sign_b    <= in_sign_b;
            exp_a     <= (in_exp_a == '0) ? (fp_pkg::EXP_W)'(1) : in_exp_a;
            exp_b     <= (in_exp_b == '0) ? (fp_pkg::EXP_W)'(1) : in_exp_b;
            man_a     <= {in_exp_a != '0, in_frac_a};
            man_b     <= {in_exp_b != '0, in_frac_b};
            spec_q    <= spec_in;
            spec_word <= spec_in_word;
        end
        if (state == fp_pkg::ADD_ALIGN) begin
            sum_q    <= sum_d;
            sum_exp  <= a_big ? exp_a : exp_b;
            sum_sign <= sign_d;
        end
        if (state == fp_pkg::ADD_NORM)
            result_q <= spec_q ? spec_word : packed_res;
    end

    assign port.busy   = (state != fp_pkg::ADD_IDLE);
    assign port.done   = (state == fp_pkg::ADD_DONE);
    assign port.result = result_q;

    a_done_after_busy: assert property (@(posedge CLK) disable iff (Reset)
        port.done |-> $past(port.busy));
    a_done_single: assert property (@(posedge CLK) disable iff (Reset)
        port.done |=> !port.done);
    a_state_known: assert property (@(posedge CLK) disable iff (Reset)
        !$isunknown(state));

endmodule

/* verilog/fp_axil_regs.sv */
/*
 * AXI4-Lite register block of the add accelerator
 * operands, control, status and result, start pulse to the core
 */
module fp_axil_regs (
    input  logic                      CLK,
    input  logic                      Reset,
    input  logic [fp_pkg::ADDR_W-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [fp_pkg::ADDR_W-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    fp_op_if.host                     port
);

    logic              wr_fire;
    logic              rd_fire;
    logic [31:0]       opa_q;
    logic [31:0]       opb_q;
    logic [31:0]       result_q;
    logic              done_q;     // sticky until next start
    fp_pkg::axi_resp_e wr_resp;
    fp_pkg::axi_resp_e bresp_q;
    fp_pkg::axi_resp_e rd_resp;
    fp_pkg::axi_resp_e rresp_q;
    logic [31:0]       rd_data;

    // one write in flight, blocked while the response waits
    assign wr_fire = awvalid & wvalid & ~bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rd_fire = arvalid & ~rvalid;
    assign arready = rd_fire;

    assign port.start = wr_fire && (awaddr == fp_pkg::REG_CTRL) && wdata[0] && !port.busy;
    assign port.op    = fp_pkg::fp_op_e'(wdata[1]);
    assign port.opa   = opa_q;
    assign port.opb   = opb_q;

    always_comb begin
        case (awaddr)
            fp_pkg::REG_OPA, fp_pkg::REG_OPB,
            fp_pkg::REG_STATUS, fp_pkg::REG_RESULT:
                wr_resp = fp_pkg::RESP_OKAY;
            fp_pkg::REG_CTRL:
                wr_resp = (wdata[0] && port.busy) ? fp_pkg::RESP_SLVERR : fp_pkg::RESP_OKAY;
            default:
                wr_resp = fp_pkg::RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_resp = fp_pkg::RESP_OKAY;
        case (araddr)
            fp_pkg::REG_OPA:    rd_data = opa_q;
            fp_pkg::REG_OPB:    rd_data = opb_q;
            fp_pkg::REG_CTRL:   rd_data = '0;            // write-only
            fp_pkg::REG_STATUS: rd_data = {30'd0, done_q, port.busy};
            fp_pkg::REG_RESULT: rd_data = result_q;
            default: begin
                rd_data = '0;
                rd_resp = fp_pkg::RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            opa_q    <= '0;
            opb_q    <= '0;
            result_q <= '0;
            done_q   <= 1'b0;
            bvalid   <= 1'b0;
            bresp_q  <= fp_pkg::RESP_OKAY;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp_q  <= fp_pkg::RESP_OKAY;
        end else begin
            if (wr_fire && awaddr == fp_pkg::REG_OPA)
                opa_q <= wdata;
            if (wr_fire && awaddr == fp_pkg::REG_OPB)
                opb_q <= wdata;

            if (port.start)
                done_q <= 1'b0;
            else if (port.done)
                done_q <= 1'b1;
            if (port.done)
                result_q <= port.result;

            if (wr_fire) begin
                bvalid  <= 1'b1;
                bresp_q <= wr_resp;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid  <= 1'b1;
                rdata   <= rd_data;
                rresp_q <= rd_resp;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign bresp = bresp_q;
    assign rresp = rresp_q;

    a_bvalid_hold: assert property (@(posedge CLK) disable iff (Reset)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_rvalid_hold: assert property (@(posedge CLK) disable iff (Reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));
    // core must take the request on that same edge
    a_start_idle: assert property (@(posedge CLK) disable iff (Reset)
        port.start |-> !port.busy ##1 port.busy);

endmodule

/* verilog/fp_op_if.sv */
/*
 * adder request channel
 * one operation and its result between the register block and the core
 */
interface fp_op_if;

    logic           start;     // single cycle, honoured only when idle
    fp_pkg::fp_op_e op;
    logic [31:0]    opa;
    logic [31:0]    opb;

    logic           busy;
    logic           done;      // single cycle
    logic [31:0]    result;

    modport host (
        output start, op, opa, opb,
        input  busy, done, result
    );

    modport core (
        input  start, op, opa, opb,
        output busy, done, result
    );

endinterface

/* verilog/fp_pkg.sv */
/*
 * binary32 add accelerator package
 * field widths, AXI4-Lite register map and the enums shared by the RTL
 */
package fp_pkg;

    // IEEE-754 binary32 fields
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;

    // carry + hidden + fraction + guard/round/sticky
    localparam int FRAC_W = MAN_W + 5;

    localparam logic [EXP_W-1:0] EXP_MAX = '1;    // inf and NaN exponent
    localparam logic [31:0]      QNAN    = 32'h7FC0_0000;

    // register map, byte offsets
    localparam int ADDR_W = 5;

    localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;
    localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;

    typedef enum logic [0:0] {
        FP_ADD = 1'b0,
        FP_SUB = 1'b1
    } fp_op_e;

    // adder core sequence
    typedef enum logic [1:0] {
        ADD_IDLE  = 2'd0,
        ADD_ALIGN = 2'd1,
        ADD_NORM  = 2'd2,
        ADD_DONE  = 2'd3
    } add_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

/* verilog/lead_one_enc.sv */
/*
 * leading-one encoder, 32 bits
 * four 8-bit priority encoders merged pairwise into 16 and 32 bits
 */
module lead_one_enc (
    input  logic [31:0] in,
    output logic [4:0]  pos,
    output logic        found
);

    logic [3:0][2:0] q8;     // index inside each byte
    logic [3:0]      v8;
    logic [1:0][3:0] q16;
    logic [1:0]      v16;

    function automatic logic [2:0] penc8(input logic [7:0] d);
        logic hi;
        begin
            hi = |d[7:4];
            penc8[2] = hi;
            penc8[1] = hi ? |d[7:6] : |d[3:2];
            penc8[0] = hi ? (d[7] | (~d[6] & d[5])) : (d[3] | (~d[2] & d[1]));
        end
    endfunction

    for (genvar i = 0; i < 4; i++) begin : g_byte
        assign q8[i] = penc8(in[8*i +: 8]);
        assign v8[i] = |in[8*i +: 8];
    end

    // upper half of each pair wins
    for (genvar j = 0; j < 2; j++) begin : g_half
        assign v16[j] = v8[2*j+1] | v8[2*j];
        assign q16[j] = v8[2*j+1] ? {1'b1, q8[2*j+1]} : {1'b0, q8[2*j]};
    end

    assign found = |v16;
    assign pos   = v16[1] ? {1'b1, q16[1]} : {1'b0, q16[0]};

endmodule
